/* common/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	localparam int INSN_W = 16;
	localparam int REG_W = 4;
	localparam int OPC_W = 5;	// ins[15:11]
	localparam int ALU_OP_W = 4;
	localparam int COND_W = 3;

	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd7;

	localparam logic [COND_W-1:0] COND_EQZ = 3'b000;	// also jr
	localparam logic [COND_W-1:0] COND_NEZ = 3'b001;	// also jalr
	localparam logic [COND_W-1:0] COND_LTZ = 3'b010;
	localparam logic [COND_W-1:0] COND_GEZ = 3'b011;
	localparam logic [COND_W-1:0] COND_ALWAYS = 3'b110;
	localparam logic [COND_W-1:0] COND_LINK = 3'b111;

	localparam logic [REG_W-1:0] REG_LINK = 4'd1;
	localparam logic [REG_W-1:0] REG_SP = 4'd2;
	localparam logic [REG_W-1:0] PRIV_REG_LO = 4'd3;	// user mode may not touch 3..6
	localparam logic [REG_W-1:0] PRIV_REG_HI = 4'd6;

	typedef union packed {
		struct packed {
			logic [OPC_W-1:0] opc;
			logic [2:0] rd;	// ins[10:8]
			logic [2:0] rs;	// ins[7:5]
			logic [4:0] fn;
		} r;
		struct packed {
			logic [OPC_W-1:0] opc;
			logic [2:0] rg;
			logic [7:0] off;	// bit 0 is the sign
		} o;
	} insn_word_u;

endpackage

`default_nettype wire

/* source/mem_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_op_decode #(
	parameter int XLEN = 32
) (
	input wire decode_pkg::insn_word_u ins,
	output logic hit,
	output logic bad_enc,
	output logic load,
	output logic store,
	output logic byte_access,
	output logic [decode_pkg::REG_W-1:0] rs1,
	output logic [decode_pkg::REG_W-1:0] rs2,
	output logic [decode_pkg::REG_W-1:0] rd,
	output logic [XLEN-1:0] imm
);

	logic reg_form;
	logic sp_form;
	logic [decode_pkg::REG_W-1:0] data_reg;

	// 00_01x and 00_11x
	assign reg_form = ins.r.opc[4:3] == 2'b00 && ins.r.opc[1];
	// lwsp 10_010, swsp 10_110
	assign sp_form = ins.r.opc[4:3] == 2'b10 && ins.r.opc[1:0] == 2'b10;
	assign hit = reg_form || sp_form;

	assign store = hit && ins.r.opc[2];
	assign load = hit && !ins.r.opc[2];
	assign byte_access = reg_form && ins.r.opc[0];
	assign bad_enc = reg_form && ins.r.rs == 3'd7;	// base field 7 reserved

	// sp forms reach all 16 registers through ins[7]
	assign data_reg = reg_form ? {1'b1, ins.r.rd} : {ins.r.rs[2], ins.r.rd};

	assign rs1 = sp_form ? decode_pkg::REG_SP : {1'b1, ins.r.rs};
	assign rs2 = store ? data_reg : '0;
	assign rd = load ? data_reg : '0;

	always_comb begin
		if (sp_form)
			imm = {{(XLEN-8){1'b0}}, ins.r.fn[0], ins.r.rs[1:0], ins.r.fn[4:1], 1'b0};
		else if (ins.r.opc[0])
			imm = {{(XLEN-5){ins.r.fn[4]}}, ins.r.fn};	// byte offset
		else
			imm = {{(XLEN-5){ins.r.fn[0]}}, ins.r.fn[4:1], 1'b0};
	end

endmodule

`default_nettype wire

/* source/alu_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode #(
	parameter int XLEN = 32
) (
	input wire decode_pkg::insn_word_u ins,
	output logic hit,
	output logic bad_enc,
	output logic [decode_pkg::ALU_OP_W-1:0] op,
	output logic [decode_pkg::REG_W-1:0] rs1,
	output logic [decode_pkg::REG_W-1:0] rs2,
	output logic [decode_pkg::REG_W-1:0] rd,
	output logic needs_rs2,
	output logic set_cc,
	output logic [XLEN-1:0] imm
);

	logic [decode_pkg::REG_W-1:0] hi_rd;
	logic [decode_pkg::REG_W-1:0] hi_rs;
	logic shift_bad;

	assign hi_rd = {1'b1, ins.r.rd};
	assign hi_rs = {1'b1, ins.r.rs};
	// register shift amount must keep bit 4 clear, bit 2 is always reserved
	assign shift_bad = ins.r.fn[2] || (!ins.r.fn[3] && ins.r.fn[4]);

	always_comb begin
		hit = 1'b1;
		bad_enc = 1'b0;
		op = decode_pkg::ALU_ADD;
		rs1 = '0;
		rs2 = '0;
		rd = hi_rd;
		needs_rs2 = 1'b0;
		set_cc = 1'b0;
		imm = {{(XLEN-8){ins.r.rs[2]}}, ins.r.rs, ins.r.fn};	// ins[7:0] signed
		case (ins.r.opc)
		5'b01_000, 5'b01_010: rs1 = ins.r.opc[1] ? '0 : hi_rd;	// addi, li
		5'b01_011: begin	// lui
			rd = {ins.r.rs[2], ins.r.rd};
			imm = {{(XLEN-15){1'b0}}, ins.r.rs[1:0], ins.r.fn, 8'b0};
		end
		5'b01_100: begin
			rs1 = hi_rd;
			rs2 = hi_rs;
			imm = {{(XLEN-4){1'b0}}, ins.r.rs, ins.r.fn[4]};
			case (ins.r.fn[1:0])
			2'b00, 2'b01: begin
				op = ins.r.fn[0] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
				needs_rs2 = !ins.r.fn[3];
				bad_enc = shift_bad;
			end
			2'b10: begin
				op = decode_pkg::ALU_AND;
				imm = {{(XLEN-6){1'b0}}, ins.r.rs, ins.r.fn[4:2]};
			end
			default: begin
				needs_rs2 = 1'b1;
				imm = '0;
				if (ins.r.fn[3:2] == 2'b00) begin
					bad_enc = 1'b1;
				end else if (ins.r.fn[3:2] == 2'b01) begin
					op = ins.r.fn[4] ? decode_pkg::ALU_AND : decode_pkg::ALU_OR;
				end else begin	// compare
					rs2 = {ins.r.fn[4], ins.r.rs};
					op = ins.r.fn[2] ? decode_pkg::ALU_ADD : decode_pkg::ALU_SUB;
					set_cc = 1'b1;
				end
			end
			endcase
		end
		5'b11_100: begin
			rs1 = hi_rd;
			rs2 = hi_rs;
			imm = {{(XLEN-4){1'b0}}, ins.r.rs, ins.r.fn[4]};
			case (ins.r.fn[1:0])
			2'b00, 2'b01: begin
				op = ins.r.fn[0] ? decode_pkg::ALU_XOR : decode_pkg::ALU_SLL;
				needs_rs2 = !ins.r.fn[3];
				bad_enc = shift_bad;
			end
			2'b10: begin
				op = decode_pkg::ALU_OR;
				imm = {{(XLEN-6){1'b0}}, ins.r.rs, ins.r.fn[4:2]};
			end
			default: hit = 1'b0;	// mul/div and friends
			endcase
		end
		5'b10_100: begin	// mov, add, sub
			hit = ins.r.fn[2:0] == 3'b001 || ins.r.fn[1];
			rd = {ins.r.fn[3], ins.r.rd};
			rs1 = ins.r.fn[1] ? {ins.r.fn[3], ins.r.rd} : '0;
			rs2 = {ins.r.fn[4], ins.r.rs};
			needs_rs2 = 1'b1;
			op = ins.r.fn[1:0] == 2'b11 ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
			imm = '0;
		end
		default: hit = 1'b0;
		endcase
		if (ins.r.opc == 5'b10_100 && ins.r.fn[2])
			hit = 1'b0;	// 1xx belongs to nobody
	end

endmodule

`default_nettype wire

/* source/branch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_decode #(
	parameter int XLEN = 32
) (
	input wire decode_pkg::insn_word_u ins,
	output logic hit,
	output logic bad_enc,
	output logic br,
	output logic jmp,
	output logic [decode_pkg::COND_W-1:0] cond,
	output logic [decode_pkg::REG_W-1:0] rs1,
	output logic [decode_pkg::REG_W-1:0] rd,
	output logic needs_rs2,
	output logic [XLEN-1:0] imm
);

	always_comb begin
		hit = 1'b1;
		bad_enc = 1'b0;
		br = 1'b0;
		jmp = 1'b0;
		cond = decode_pkg::COND_EQZ;
		rs1 = '0;
		rd = '0;
		needs_rs2 = 1'b0;
		imm = {{(XLEN-8){ins.o.off[0]}}, ins.o.off[7:1], 1'b0};
		casez (ins.o.opc)
		5'b01_?01: begin	// jal, j
			br = 1'b1;
			cond = ins.o.opc[2] ? decode_pkg::COND_ALWAYS : decode_pkg::COND_LINK;
			rd = ins.o.opc[2] ? '0 : decode_pkg::REG_LINK;
			imm = {{(XLEN-11){ins.o.off[0]}}, ins.o.rg, ins.o.off[7:1], 1'b0};
		end
		5'b?1_11?: begin	// beqz/bnez, bltz/bgez
			br = 1'b1;
			if (ins.o.opc[4])
				cond = ins.o.opc[0] ? decode_pkg::COND_GEZ : decode_pkg::COND_LTZ;
			else
				cond = ins.o.opc[0] ? decode_pkg::COND_NEZ : decode_pkg::COND_EQZ;
			rs1 = {1'b1, ins.o.rg};
		end
		5'b10_100: begin	// jr, jalr
			hit = ins.r.fn[2:0] == 3'b000;
			jmp = 1'b1;
			cond = ins.r.fn[4] ? decode_pkg::COND_NEZ : decode_pkg::COND_EQZ;
			rs1 = {ins.o.off[7], ins.o.rg};
			rd = ins.r.fn[4] ? decode_pkg::REG_LINK : '0;
			needs_rs2 = 1'b1;
			imm = '0;
			bad_enc = ins.r.fn[3:2] != 2'b00 || ins.r.rs[1:0] != 2'b00;
		end
		default: hit = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
	parameter int XLEN = 32
) (
	input wire clk,
	input wire rst_n,
	input wire ins_valid,
	input wire supmode,
	input wire mem_hit, mem_bad_enc, mem_load, mem_store, mem_byte_access,
	input wire [decode_pkg::REG_W-1:0] mem_rs1, mem_rs2, mem_rd,
	input wire [XLEN-1:0] mem_imm,
	input wire alu_hit, alu_bad_enc, alu_needs_rs2, alu_set_cc,
	input wire [decode_pkg::ALU_OP_W-1:0] alu_op,
	input wire [decode_pkg::REG_W-1:0] alu_rs1, alu_rs2, alu_rd,
	input wire [XLEN-1:0] alu_imm,
	input wire br_hit, br_bad_enc, br_br, br_jmp, br_needs_rs2,
	input wire [decode_pkg::COND_W-1:0] br_cond,
	input wire [decode_pkg::REG_W-1:0] br_rs1, br_rd,
	input wire [XLEN-1:0] br_imm,
	output logic decoded_valid,
	output logic trap,
	output logic [decode_pkg::ALU_OP_W-1:0] op,
	output logic [decode_pkg::REG_W-1:0] rs1, rs2, rd,
	output logic needs_rs2,
	output logic set_cc,
	output logic load,
	output logic store,
	output logic byte_access,
	output logic br,
	output logic jmp,
	output logic [decode_pkg::COND_W-1:0] cond,
	output logic [XLEN-1:0] imm
);

	logic c_bad, c_trap, c_load, c_store, c_byte, c_br, c_jmp, c_needs_rs2, c_set_cc;
	logic [decode_pkg::ALU_OP_W-1:0] c_op;
	logic [decode_pkg::REG_W-1:0] c_rs1, c_rs2, c_rd;
	logic [decode_pkg::COND_W-1:0] c_cond;
	logic [XLEN-1:0] c_imm;

	function automatic logic is_priv(input logic [decode_pkg::REG_W-1:0] r);
		return r >= decode_pkg::PRIV_REG_LO && r <= decode_pkg::PRIV_REG_HI;
	endfunction

	always_comb begin
		c_bad = 1'b1;	// no unit owns it
		c_op = decode_pkg::ALU_ADD;
		{c_rs1, c_rs2, c_rd} = '0;
		{c_load, c_store, c_byte, c_br, c_jmp, c_needs_rs2, c_set_cc} = '0;
		c_cond = decode_pkg::COND_EQZ;
		c_imm = '0;
		if (mem_hit) begin
			c_bad = mem_bad_enc;
			{c_rs1, c_rs2, c_rd} = {mem_rs1, mem_rs2, mem_rd};
			{c_load, c_store, c_byte} = {mem_load, mem_store, mem_byte_access};
			c_cond = {{(decode_pkg::COND_W-1){1'b0}}, mem_byte_access};
			c_imm = mem_imm;
		end else if (alu_hit) begin
			c_bad = alu_bad_enc;
			c_op = alu_op;
			{c_rs1, c_rs2, c_rd} = {alu_rs1, alu_rs2, alu_rd};
			{c_needs_rs2, c_set_cc} = {alu_needs_rs2, alu_set_cc};
			c_imm = alu_imm;
		end else if (br_hit) begin
			c_bad = br_bad_enc;
			{c_rs1, c_rd} = {br_rs1, br_rd};
			{c_br, c_jmp, c_needs_rs2} = {br_br, br_jmp, br_needs_rs2};
			c_cond = br_cond;
			c_imm = br_imm;
		end
		c_trap = c_bad || (!supmode && (is_priv(c_rs1) || is_priv(c_rs2) || is_priv(c_rd)));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			decoded_valid <= 1'b0;
			{trap, load, store, br, jmp} <= '0;
		end else begin
			decoded_valid <= ins_valid;
			if (ins_valid) begin
				trap <= c_trap;
				load <= c_load && !c_trap;	// nothing moves on a trap
				store <= c_store && !c_trap;
				br <= c_br && !c_trap;
				jmp <= c_jmp && !c_trap;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ins_valid) begin
			op <= c_op;
			{rs1, rs2, rd} <= {c_rs1, c_rs2, c_rd};
			{needs_rs2, set_cc, byte_access} <= {c_needs_rs2, c_set_cc, c_byte};
			cond <= c_cond;
			imm <= c_imm;
		end
	end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode #(
	parameter int XLEN = 32
) (
	input wire clk,
	input wire rst_n,
	input wire [decode_pkg::INSN_W-1:0] ins,
	input wire ins_valid,
	input wire supmode,
	output logic decoded_valid,
	output logic trap,
	output logic [decode_pkg::ALU_OP_W-1:0] op,
	output logic [decode_pkg::REG_W-1:0] rs1, rs2, rd,
	output logic needs_rs2,
	output logic set_cc,
	output logic load,
	output logic store,
	output logic byte_access,
	output logic br,
	output logic jmp,
	output logic [decode_pkg::COND_W-1:0] cond,
	output logic [XLEN-1:0] imm
);

	wire mem_hit, mem_bad_enc, mem_load, mem_store, mem_byte_access;
	wire [decode_pkg::REG_W-1:0] mem_rs1, mem_rs2, mem_rd;
	wire [XLEN-1:0] mem_imm;
	wire alu_hit, alu_bad_enc, alu_needs_rs2, alu_set_cc;
	wire [decode_pkg::ALU_OP_W-1:0] alu_op;
	wire [decode_pkg::REG_W-1:0] alu_rs1, alu_rs2, alu_rd;
	wire [XLEN-1:0] alu_imm;
	wire br_hit, br_bad_enc, br_br, br_jmp, br_needs_rs2;
	wire [decode_pkg::COND_W-1:0] br_cond;
	wire [decode_pkg::REG_W-1:0] br_rs1, br_rd;
	wire [XLEN-1:0] br_imm;

	mem_op_decode #(.XLEN(XLEN)) u_mem (
		.ins(ins), .hit(mem_hit), .bad_enc(mem_bad_enc), .load(mem_load),
		.store(mem_store), .byte_access(mem_byte_access),
		.rs1(mem_rs1), .rs2(mem_rs2), .rd(mem_rd), .imm(mem_imm)
	);

	alu_op_decode #(.XLEN(XLEN)) u_alu (
		.ins(ins), .hit(alu_hit), .bad_enc(alu_bad_enc), .op(alu_op),
		.rs1(alu_rs1), .rs2(alu_rs2), .rd(alu_rd),
		.needs_rs2(alu_needs_rs2), .set_cc(alu_set_cc), .imm(alu_imm)
	);

	branch_decode #(.XLEN(XLEN)) u_branch (
		.ins(ins), .hit(br_hit), .bad_enc(br_bad_enc), .br(br_br), .jmp(br_jmp),
		.cond(br_cond), .rs1(br_rs1), .rd(br_rd), .needs_rs2(br_needs_rs2), .imm(br_imm)
	);

	decode_stage #(.XLEN(XLEN)) u_stage (
		.clk(clk), .rst_n(rst_n), .ins_valid(ins_valid), .supmode(supmode),
		.mem_hit(mem_hit), .mem_bad_enc(mem_bad_enc), .mem_load(mem_load),
		.mem_store(mem_store), .mem_byte_access(mem_byte_access),
		.mem_rs1(mem_rs1), .mem_rs2(mem_rs2), .mem_rd(mem_rd), .mem_imm(mem_imm),
		.alu_hit(alu_hit), .alu_bad_enc(alu_bad_enc), .alu_needs_rs2(alu_needs_rs2),
		.alu_set_cc(alu_set_cc), .alu_op(alu_op),
		.alu_rs1(alu_rs1), .alu_rs2(alu_rs2), .alu_rd(alu_rd), .alu_imm(alu_imm),
		.br_hit(br_hit), .br_bad_enc(br_bad_enc), .br_br(br_br), .br_jmp(br_jmp),
		.br_needs_rs2(br_needs_rs2), .br_cond(br_cond),
		.br_rs1(br_rs1), .br_rd(br_rd), .br_imm(br_imm),
		.decoded_valid(decoded_valid), .trap(trap), .op(op),
		.rs1(rs1), .rs2(rs2), .rd(rd), .needs_rs2(needs_rs2), .set_cc(set_cc),
		.load(load), .store(store), .byte_access(byte_access),
		.br(br), .jmp(jmp), .cond(cond), .imm(imm)
	);

endmodule

`default_nettype wire

/* test/instr_decode_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode_properties (
	input wire clk,
	input wire rst_n,
	input wire ins_valid,
	input wire decoded_valid,
	input wire load,
	input wire store,
	input wire br,
	input wire jmp
);

	// one result per accepted word, one cycle later
	valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
		decoded_valid == $past(ins_valid))
		else $error("decoded_valid does not follow ins_valid by one cycle");

	quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !decoded_valid)
		else $error("decoded_valid high in the cycle after reset");

	mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(load && store))
		else $error("load and store both high");

	flow_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(br && jmp))
		else $error("br and jmp both high");

endmodule

bind instr_decode instr_decode_properties u_props (
	.clk(clk), .rst_n(rst_n), .ins_valid(ins_valid), .decoded_valid(decoded_valid),
	.load(load), .store(store), .br(br), .jmp(jmp)
);

`default_nettype wire

/* test/tb_instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decode;

	logic clk;
	logic rst_n;
	logic [15:0] ins;
	logic ins_valid;
	logic supmode;
	logic decoded_valid, trap, needs_rs2, set_cc, load, store, byte_access, br, jmp;
	logic [decode_pkg::ALU_OP_W-1:0] op;
	logic [decode_pkg::REG_W-1:0] rs1, rs2, rd;
	logic [decode_pkg::COND_W-1:0] cond;
	logic [31:0] imm;

	logic exp_trap, exp_needs_rs2, exp_set_cc, exp_load, exp_store, exp_byte, exp_br, exp_jmp;
	logic [decode_pkg::ALU_OP_W-1:0] exp_op;
	logic [decode_pkg::REG_W-1:0] exp_rs1, exp_rs2, exp_rd;
	logic [decode_pkg::COND_W-1:0] exp_cond;
	logic [31:0] exp_imm;

	integer seed;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	instr_decode #(.XLEN(32)) dut0 (
		.clk(clk), .rst_n(rst_n), .ins(ins), .ins_valid(ins_valid), .supmode(supmode),
		.decoded_valid(decoded_valid), .trap(trap), .op(op), .rs1(rs1), .rs2(rs2), .rd(rd),
		.needs_rs2(needs_rs2), .set_cc(set_cc), .load(load), .store(store),
		.byte_access(byte_access), .br(br), .jmp(jmp), .cond(cond), .imm(imm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic reg_is_protected(input logic [decode_pkg::REG_W-1:0] r);
		return r inside {[decode_pkg::PRIV_REG_LO:decode_pkg::PRIV_REG_HI]};
	endfunction

	// expected bundle for one word, written into the exp_ variables
	function automatic void ref_decode(input logic [15:0] w, input logic sup);
		logic [4:0] opc;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [4:0] f;
		logic hit;
		logic bad;
		opc = w[15:11];
		ra = w[10:8];
		rb = w[7:5];
		f = w[4:0];
		bad = 1'b0;
		exp_op = decode_pkg::ALU_ADD;
		{exp_rs1, exp_rs2, exp_rd} = '0;
		{exp_needs_rs2, exp_set_cc, exp_load, exp_store, exp_byte, exp_br, exp_jmp} = '0;
		exp_cond = decode_pkg::COND_EQZ;
		exp_imm = '0;
		// mul/div group and 10_100 with function 1xx are unowned
		hit = !((opc == 5'b11_100 && f[1:0] == 2'b11) || (opc == 5'b10_100 && f[2]));
		if (hit) begin
			casez (opc)
			5'b00_?1?: begin	// lw, lb, sw, sb
				exp_load = !opc[2];
				exp_store = opc[2];
				exp_byte = opc[0];
				exp_cond = {2'b00, opc[0]};
				exp_rs1 = {1'b1, rb};
				if (opc[2])
					exp_rs2 = {1'b1, ra};
				else
					exp_rd = {1'b1, ra};
				bad = rb == 3'd7;
				exp_imm = opc[0] ? {{27{w[4]}}, w[4:0]} : {{27{w[0]}}, w[4:1], 1'b0};
			end
			5'b10_?10: begin	// lwsp, swsp
				exp_load = !opc[2];
				exp_store = opc[2];
				exp_rs1 = decode_pkg::REG_SP;
				if (opc[2])
					exp_rs2 = {w[7], ra};
				else
					exp_rd = {w[7], ra};
				exp_imm = {24'b0, w[0], w[6:1], 1'b0};
			end
			5'b01_000, 5'b01_010: begin
				exp_rd = {1'b1, ra};
				exp_rs1 = opc[1] ? 4'd0 : {1'b1, ra};
				exp_imm = {{24{w[7]}}, w[7:0]};
			end
			5'b01_011: begin
				exp_rd = {w[7], ra};
				exp_imm = {17'b0, w[6:0], 8'b0};
			end
			5'b01_100, 5'b11_100: begin
				exp_rd = {1'b1, ra};
				exp_rs1 = {1'b1, ra};
				exp_rs2 = {1'b1, rb};
				exp_imm = {28'b0, w[7:4]};
				if (!f[1]) begin	// shifts, sll and xor
					exp_needs_rs2 = !f[3];
					bad = f[2] || (!f[3] && f[4]);
					if (opc[4])
						exp_op = f[0] ? decode_pkg::ALU_XOR : decode_pkg::ALU_SLL;
					else
						exp_op = f[0] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
				end else if (!f[0]) begin
					exp_op = opc[4] ? decode_pkg::ALU_OR : decode_pkg::ALU_AND;
					exp_imm = {26'b0, w[7:2]};
				end else begin
					exp_needs_rs2 = 1'b1;
					exp_imm = '0;
					case (f[3:2])
					2'b00: bad = 1'b1;
					2'b01: exp_op = f[4] ? decode_pkg::ALU_AND : decode_pkg::ALU_OR;
					default: begin	// compare
						exp_rs2 = {w[4], rb};
						exp_op = f[2] ? decode_pkg::ALU_ADD : decode_pkg::ALU_SUB;
						exp_set_cc = 1'b1;
					end
					endcase
				end
			end
			5'b10_100: begin
				exp_needs_rs2 = 1'b1;
				if (f[1:0] == 2'b00) begin	// jr, jalr
					exp_jmp = 1'b1;
					exp_cond = f[4] ? decode_pkg::COND_NEZ : decode_pkg::COND_EQZ;
					exp_rs1 = {w[7], ra};
					exp_rd = f[4] ? decode_pkg::REG_LINK : 4'd0;
					bad = f[3:2] != 2'b00 || w[6:5] != 2'b00;
				end else begin	// mov, add, sub
					exp_rd = {f[3], ra};
					exp_rs1 = f[1] ? {f[3], ra} : 4'd0;
					exp_rs2 = {f[4], rb};
					exp_op = f[1:0] == 2'b11 ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
				end
			end
			5'b01_?01: begin
				exp_br = 1'b1;
				exp_cond = opc[2] ? decode_pkg::COND_ALWAYS : decode_pkg::COND_LINK;
				exp_rd = opc[2] ? 4'd0 : decode_pkg::REG_LINK;
				exp_imm = {{21{w[0]}}, w[10:1], 1'b0};
			end
			5'b?1_11?: begin
				exp_br = 1'b1;
				exp_cond = {1'b0, opc[4], opc[0]};
				exp_rs1 = {1'b1, ra};
				exp_imm = {{24{w[0]}}, w[7:1], 1'b0};
			end
			default: hit = 1'b0;
			endcase
		end
		exp_trap = !hit || bad || (!sup && (reg_is_protected(exp_rs1)
			|| reg_is_protected(exp_rs2) || reg_is_protected(exp_rd)));
		if (exp_trap)
			{exp_load, exp_store, exp_br, exp_jmp} = '0;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_fields();
		check_val("trap", 32'(exp_trap), 32'(trap));
		check_val("op", 32'(exp_op), 32'(op));
		check_val("rs1", 32'(exp_rs1), 32'(rs1));
		check_val("rs2", 32'(exp_rs2), 32'(rs2));
		check_val("rd", 32'(exp_rd), 32'(rd));
		check_val("needs_rs2", 32'(exp_needs_rs2), 32'(needs_rs2));
		check_val("set_cc", 32'(exp_set_cc), 32'(set_cc));
		check_val("load", 32'(exp_load), 32'(load));
		check_val("store", 32'(exp_store), 32'(store));
		check_val("byte_access", 32'(exp_byte), 32'(byte_access));
		check_val("br", 32'(exp_br), 32'(br));
		check_val("jmp", 32'(exp_jmp), 32'(jmp));
		check_val("cond", 32'(exp_cond), 32'(cond));
		check_val("imm", exp_imm, imm);
	endtask

	task automatic decode_and_check(input logic [15:0] w, input logic sup);
		int n;
		@(posedge clk);
		ins <= w;
		ins_valid <= 1'b1;
		supmode <= sup;
		@(posedge clk);
		ins_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!decoded_valid && n < 8);
		assert (decoded_valid) else begin
			timeouts++;
			$display("decoded_valid did not rise within 8 cycles for word %h", w);
		end
		if (decoded_valid) begin
			ref_decode(w, sup);
			compare_fields();
		end
	endtask

	task automatic mem_ops();
		decode_and_check({5'b00_010, 3'b001, 3'b010, 5'b00110}, 1'b1);	// lw r9, 6(r10)
		check_val("rd", 32'd9, 32'(rd));
		check_val("imm", 32'd6, imm);
		decode_and_check({5'b00_011, 3'b010, 3'b001, 5'b11111}, 1'b1);	// lb -1
		check_val("imm", 32'hffff_ffff, imm);
		check_val("byte_access", 32'd1, 32'(byte_access));
		decode_and_check({5'b00_110, 3'b110, 3'b101, 5'b00001}, 1'b0);
		check_val("imm", 32'hffff_ffe0, imm);
		decode_and_check({5'b00_111, 3'b011, 3'b000, 5'b10000}, 1'b1);
		check_val("rs2", 32'd11, 32'(rs2));
		check_val("imm", 32'hffff_fff0, imm);
		decode_and_check({5'b10_010, 3'b111, 3'b011, 5'b00101}, 1'b1);	// lwsp r7
		check_val("imm", 32'h0000_00e4, imm);
		check_val("rs1", 32'd2, 32'(rs1));
		decode_and_check({5'b10_110, 3'b000, 3'b100, 5'b00000}, 1'b1);	// swsp r8
		check_val("rs2", 32'd8, 32'(rs2));
		check_val("store", 32'd1, 32'(store));
	endtask

	task automatic alu_ops();
		decode_and_check({5'b01_000, 3'b001, 8'hfd}, 1'b1);	// addi r9, -3
		check_val("imm", 32'hffff_fffd, imm);
		decode_and_check({5'b01_010, 3'b010, 8'h7f}, 1'b1);
		decode_and_check({5'b01_011, 3'b010, 3'b011, 5'b10101}, 1'b1);	// lui r2
		check_val("imm", 32'h0000_7500, imm);
		check_val("rd", 32'd2, 32'(rd));
		decode_and_check({5'b01_100, 3'b000, 3'b001, 5'b00000}, 1'b1);
		decode_and_check({5'b01_100, 3'b001, 3'b011, 5'b11001}, 1'b1);
		decode_and_check({5'b01_100, 3'b010, 3'b101, 5'b10110}, 1'b1);	// andi
		check_val("imm", 32'h0000_002d, imm);
		decode_and_check({5'b01_100, 3'b011, 3'b100, 5'b00111}, 1'b1);
		decode_and_check({5'b01_100, 3'b011, 3'b100, 5'b10111}, 1'b1);
		decode_and_check({5'b01_100, 3'b001, 3'b010, 5'b11011}, 1'b1);	// cmp
		check_val("op", 32'(decode_pkg::ALU_SUB), 32'(op));
		check_val("set_cc", 32'd1, 32'(set_cc));
		decode_and_check({5'b01_100, 3'b001, 3'b010, 5'b01111}, 1'b1);
		decode_and_check({5'b11_100, 3'b100, 3'b010, 5'b01000}, 1'b1);
		decode_and_check({5'b11_100, 3'b101, 3'b110, 5'b00001}, 1'b1);
		decode_and_check({5'b11_100, 3'b110, 3'b001, 5'b01110}, 1'b1);
		decode_and_check({5'b10_100, 3'b101, 3'b010, 5'b01001}, 1'b1);	// mov r13, r2
		check_val("rd", 32'd13, 32'(rd));
		check_val("rs1", 32'd0, 32'(rs1));
		decode_and_check({5'b10_100, 3'b000, 3'b111, 5'b11010}, 1'b1);
		decode_and_check({5'b10_100, 3'b111, 3'b000, 5'b00011}, 1'b1);
		check_val("op", 32'(decode_pkg::ALU_SUB), 32'(op));
	endtask

	task automatic branch_jumps();
		decode_and_check({5'b01_001, 3'b000, 8'b0001_0100}, 1'b1);	// jal +20
		check_val("imm", 32'd20, imm);
		check_val("rd", 32'(decode_pkg::REG_LINK), 32'(rd));
		decode_and_check({5'b01_101, 3'b111, 8'hff}, 1'b1);	// j -2
		check_val("imm", 32'hffff_fffe, imm);
		check_val("cond", 32'(decode_pkg::COND_ALWAYS), 32'(cond));
		decode_and_check({5'b01_110, 3'b001, 8'b0000_1000}, 1'b1);
		decode_and_check({5'b01_111, 3'b010, 8'b1111_0001}, 1'b1);	// bnez -16
		check_val("imm", 32'hffff_fff0, imm);
		decode_and_check({5'b11_110, 3'b011, 8'h22}, 1'b1);
		decode_and_check({5'b11_111, 3'b100, 8'hfd}, 1'b1);
		check_val("cond", 32'(decode_pkg::COND_GEZ), 32'(cond));
		decode_and_check({5'b10_100, 3'b001, 3'b100, 5'b00000}, 1'b1);	// jr r9
		check_val("rs1", 32'd9, 32'(rs1));
		decode_and_check({5'b10_100, 3'b110, 3'b100, 5'b10000}, 1'b1);	// jalr r14
		check_val("jmp", 32'd1, 32'(jmp));
		check_val("rd", 32'(decode_pkg::REG_LINK), 32'(rd));
	endtask

	task automatic privilege_trap();
		logic [15:0] words [0:3];
		words[0] = {5'b10_010, 3'b011, 3'b000, 5'b00000};	// lwsp r3
		words[1] = {5'b01_011, 3'b100, 3'b000, 5'b00001};	// lui r4
		words[2] = {5'b10_100, 3'b101, 3'b001, 5'b10001};	// mov r5, r9
		words[3] = {5'b10_100, 3'b110, 3'b000, 5'b00000};	// jr r6
		foreach (words[i]) begin
			decode_and_check(words[i], 1'b0);
			check_val("trap", 32'd1, 32'(trap));
			decode_and_check(words[i], 1'b1);
			check_val("trap", 32'd0, 32'(trap));
		end
	endtask

	task automatic illegal_words();
		logic [15:0] words [0:8];
		words[0] = 16'h0000;
		words[1] = {5'b11_100, 3'b000, 3'b000, 5'b00011};	// mul/div slot
		words[2] = {5'b00_010, 3'b000, 3'b111, 5'b00000};	// base field 7
		words[3] = {5'b00_110, 3'b001, 3'b111, 5'b00010};
		words[4] = {5'b10_100, 3'b001, 3'b001, 5'b00100};
		words[5] = {5'b10_100, 3'b001, 3'b010, 5'b00000};	// jr reserved bits
		words[6] = {5'b01_100, 3'b000, 3'b000, 5'b00011};
		words[7] = {5'b01_100, 3'b000, 3'b000, 5'b00100};
		words[8] = {5'b11_000, 11'h000};
		foreach (words[i]) begin
			decode_and_check(words[i], 1'b1);
			check_val("trap", 32'd1, 32'(trap));
			check_val("load/store/br/jmp", 32'd0, 32'({load, store, br, jmp}));
		end
	endtask

	task automatic random_stream();
		int sent;
		int pulses;
		int cycles;
		logic [31:0] r;
		logic [15:0] cur_w;
		logic [15:0] prev_w;
		logic cur_v;
		logic cur_sup;
		logic prev_v;
		logic prev_sup;
		sent = 0;
		pulses = 0;
		cycles = 0;
		prev_v = 1'b0;
		prev_w = '0;
		prev_sup = 1'b0;
		while ((sent < 200 || prev_v) && cycles < 2000) begin
			@(posedge clk);
			r = $random(seed);
			cur_v = sent < 200 && r[1:0] != 2'b00;	// gaps about one cycle in four
			cur_w = r[31:16];
			cur_sup = r[2];
			ins <= cur_w;
			ins_valid <= cur_v;
			supmode <= cur_sup;
			if (cur_v)
				sent++;
			@(negedge clk);
			cycles++;
			check_val("decoded_valid", 32'(prev_v), 32'(decoded_valid));
			if (decoded_valid) begin
				pulses++;
				ref_decode(prev_w, prev_sup);
				compare_fields();
			end
			prev_v = cur_v;
			prev_w = cur_w;
			prev_sup = cur_sup;
		end
		assert (sent == 200 && !prev_v) else begin
			timeouts++;
			$display("random stream ran out of cycles after %0d words", sent);
		end
		check_val("decoded_valid pulses", 32'd200, pulses);
	endtask

	initial begin
		seed = 81649;
		rst_n = 1'b0;
		ins = '0;
		ins_valid = 1'b0;
		supmode = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		mem_ops();
		alu_ops();
		branch_jumps();
		privilege_trap();
		illegal_words();
		random_stream();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/decode_pkg.sv
source/mem_op_decode.sv
source/alu_op_decode.sv
source/branch_decode.sv
source/decode_stage.sv
source/instr_decode.sv
test/instr_decode_properties.sv
test/tb_instr_decode.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_instr_decode
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
